/* sim.f */
design/swerve_regs_pkg.sv
design/reg_addr_decode.sv
design/drive_channel.sv
design/rotation_channel.sv
design/rotation_settings.sv
design/read_return.sv
design/swerve_reg_file.sv
tb/swerve_reg_file_tb.sv

/* Bender.yml */
package:
  name: swerve_reg_file

sources:
  - design/swerve_regs_pkg.sv
  - design/reg_addr_decode.sv
  - design/drive_channel.sv
  - design/rotation_channel.sv
  - design/rotation_settings.sv
  - design/read_return.sv
  - design/swerve_reg_file.sv
  - target: simulation
    files:
      - tb/swerve_reg_file_tb.sv

/* tb/swerve_reg_file_tb.sv */
/*
 Testbench for the swerve-drive register block. Random bus traffic is compared
 against a byte-image reference model by concurrent assertions.
*/
`timescale 1ns/1ps

module swerve_reg_file_tb;

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 3;
    localparam int DIRECTED_MAX = 400;  // Upper bound of the directed phases
    localparam int RAND_CYCLES  = 300;
    localparam int WATCHDOG_NS  = (RESET_CYCLES + DIRECTED_MAX + RAND_CYCLES) * CLK_PERIOD * 2;

    logic             clock;
    logic             arst_n;
    logic [5:0]       address;
    logic             write_en;
    logic             read_en;
    logic [7:0]       wr_data;
    logic [7:0]       rd_data;
    logic [3:0]       drive_fault;
    logic [3:0][6:0]  drive_temp;
    logic [3:0]       drive_brake, drive_enable, drive_direction;
    logic [3:0][4:0]  drive_pwm;
    logic [3:0]       rot_fault, rot_startup_fail;
    logic [3:0][5:0]  rot_temp;
    logic [3:0]       rot_brake, rot_enable, rot_direction;
    logic [3:0][11:0] target_angle, current_angle;
    logic [3:0]       angle_done, update_angle, abort_angle;
    logic             enable_hammer, enable_stall_chk;
    logic [1:0]       retry_count;
    logic [2:0]       consec_chg;
    logic [3:0]       fwd_count, rvs_count;
    logic [7:0]       delay_target, profile_offset, cruise_power;

    // Reference model state
    logic [7:0]       model_map [0:63];  // Byte image where unmapped bytes stay zero
    logic [7:0]       exp_rd;
    logic [3:0]       exp_update, exp_abort;
    logic [3:0]       exp_drive_brake, exp_drive_enable, exp_drive_direction;
    logic [3:0][4:0]  exp_drive_pwm;
    logic [3:0]       exp_rot_brake, exp_rot_enable, exp_rot_direction;
    logic [3:0][11:0] exp_target;
    logic [38:0]      exp_settings;
    int               errors = 0;
    int               cycles_checked = 0;

    swerve_reg_file swerve_reg_file_inst (.*);

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    function automatic int drive_addr(input int ch);
        return swerve_regs_pkg::DRIVE_BASE + swerve_regs_pkg::DRIVE_STRIDE * ch;
    endfunction

    function automatic int rot_addr(input int ch, input int ofs);
        return swerve_regs_pkg::ROT_BASE + swerve_regs_pkg::ROT_STRIDE * ch + ofs;
    endfunction

    // Bytes that keep what is written to them
    function automatic logic writable(input int a);
        logic hit;
        hit = (a >= swerve_regs_pkg::ADDR_GEN_CTRL) && (a <= swerve_regs_pkg::ADDR_CRUISE);
        for (int ch = 0; ch < 4; ch++) begin
            if (a == drive_addr(ch) || a == rot_addr(ch, swerve_regs_pkg::ROT_CTRL_OFS))
                hit = 1'b1;
            if (a == rot_addr(ch, swerve_regs_pkg::ROT_TARG_OFS))
                hit = 1'b1;
        end
        return hit;
    endfunction

    function automatic logic [7:0] rand_byte();
        logic [31:0] w;
        w = $urandom;
        return w[7:0];
    endfunction

    task automatic flag_mismatch(input string name, input logic [255:0] got,
                                 input logic [255:0] exp);
        errors++;
        $display("Fail %s got %0h expected %0h at %0t", name, got, exp, $time);
    endtask

    // One bus cycle driven on the falling edge
    task automatic bus_cycle(input logic wr, input logic rd, input logic [5:0] addr,
                             input logic [7:0] data);
        @(negedge clock);
        write_en = wr;
        read_en  = rd;
        address  = addr;
        wr_data  = data;
    endtask

    task automatic shuffle_status();
        logic [31:0] w;
        for (int ch = 0; ch < 4; ch++) begin
            w = $urandom;
            drive_fault[ch]      = w[0];
            drive_temp[ch]       = w[7:1];
            rot_fault[ch]        = w[8];
            rot_startup_fail[ch] = w[9];
            rot_temp[ch]         = w[15:10];
            current_angle[ch]    = w[27:16];
            angle_done[ch]       = w[28];
        end
    endtask

    // Model updates on the same edge as the DUT
    always @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 64; i++)
                model_map[i] <= '0;
            exp_rd     <= '0;
            exp_update <= '0;
            exp_abort  <= '0;
        end else begin
            if (read_en)
                exp_rd <= model_map[address];  // Pre-edge image
            if (write_en && writable(address))
                model_map[address] <= wr_data;
            for (int ch = 0; ch < 4; ch++) begin
                if (write_en && (address == 1 || address == 3))  // All or drive group
                    model_map[drive_addr(ch)] <= wr_data;
                if (write_en && (address == 1 || address == 2))  // All or rotation group
                    model_map[rot_addr(ch, 0)] <= wr_data;
                model_map[drive_addr(ch) + 1] <= {drive_fault[ch], drive_temp[ch]};
                model_map[rot_addr(ch, 1)] <= {rot_fault[ch], rot_startup_fail[ch], rot_temp[ch]};
                model_map[rot_addr(ch, 3)] <= current_angle[ch][7:0];
                model_map[rot_addr(ch, 4)] <= {angle_done[ch], 3'b000, current_angle[ch][11:8]};
                exp_update[ch] <= write_en && (address == rot_addr(ch, 4)) && wr_data[5];
                exp_abort[ch]  <= write_en && (address == rot_addr(ch, 4)) && wr_data[4];
            end
        end
    end

    // Decoded outputs as the register layout defines them
    always_comb begin
        logic [7:0] g;
        logic [7:0] h;
        for (int ch = 0; ch < 4; ch++) begin
            exp_drive_brake[ch]     = model_map[drive_addr(ch)][7];
            exp_drive_enable[ch]    = model_map[drive_addr(ch)][6];
            exp_drive_direction[ch] = model_map[drive_addr(ch)][5];
            exp_drive_pwm[ch]       = model_map[drive_addr(ch)][4:0];
            exp_rot_brake[ch]       = model_map[rot_addr(ch, 0)][7];
            exp_rot_enable[ch]      = model_map[rot_addr(ch, 0)][6];
            exp_rot_direction[ch]   = model_map[rot_addr(ch, 0)][5];
            exp_target[ch] = {model_map[rot_addr(ch, 0)][3:0], model_map[rot_addr(ch, 2)]};
        end
        g = model_map[swerve_regs_pkg::ADDR_GEN_CTRL];
        h = model_map[swerve_regs_pkg::ADDR_HAMMER];
        exp_settings = {g[7], g[1], g[6:5], g[4:2], h[7:4], h[3:0],
                        model_map[swerve_regs_pkg::ADDR_DELAY],
                        model_map[swerve_regs_pkg::ADDR_OFFSET],
                        model_map[swerve_regs_pkg::ADDR_CRUISE]};
    end

    always @(posedge clock) begin
        if (arst_n)
            cycles_checked++;
    end

    drive_ctrl_ok: assert property (@(posedge clock) disable iff (!arst_n)
        {drive_brake, drive_enable, drive_direction, drive_pwm} ==
        {exp_drive_brake, exp_drive_enable, exp_drive_direction, exp_drive_pwm})
        else flag_mismatch("{drive_brake,drive_enable,drive_direction,drive_pwm}",
            $sampled({drive_brake, drive_enable, drive_direction, drive_pwm}),
            $sampled({exp_drive_brake, exp_drive_enable, exp_drive_direction, exp_drive_pwm}));

    rot_ctrl_ok: assert property (@(posedge clock) disable iff (!arst_n)
        {rot_brake, rot_enable, rot_direction, target_angle} ==
        {exp_rot_brake, exp_rot_enable, exp_rot_direction, exp_target})
        else flag_mismatch("{rot_brake,rot_enable,rot_direction,target_angle}",
            $sampled({rot_brake, rot_enable, rot_direction, target_angle}),
            $sampled({exp_rot_brake, exp_rot_enable, exp_rot_direction, exp_target}));

    settings_ok: assert property (@(posedge clock) disable iff (!arst_n)
        {enable_hammer, enable_stall_chk, retry_count, consec_chg, fwd_count, rvs_count,
         delay_target, profile_offset, cruise_power} == exp_settings)
        else flag_mismatch("rotation settings outputs", $sampled({enable_hammer,
            enable_stall_chk, retry_count, consec_chg, fwd_count, rvs_count,
            delay_target, profile_offset, cruise_power}), $sampled(exp_settings));

    pulses_ok: assert property (@(posedge clock) disable iff (!arst_n)
        {update_angle, abort_angle} == {exp_update, exp_abort})
        else flag_mismatch("{update_angle,abort_angle}",
            $sampled({update_angle, abort_angle}), $sampled({exp_update, exp_abort}));

    rd_data_ok: assert property (@(posedge clock) disable iff (!arst_n) rd_data == exp_rd)
        else flag_mismatch("rd_data", $sampled(rd_data), $sampled(exp_rd));

    // Everything the host can see is cleared by reset
    reset_clears: assert property (@(posedge clock) !arst_n |=>
        ({drive_brake, drive_enable, drive_direction, drive_pwm, rot_brake, rot_enable,
          rot_direction, target_angle, update_angle, abort_angle, rd_data, enable_hammer,
          enable_stall_chk, retry_count, consec_chg, fwd_count, rvs_count, delay_target,
          profile_offset, cruise_power} == '0))
        else flag_mismatch("outputs after reset", $sampled({drive_brake, drive_enable,
            drive_direction, drive_pwm, rot_brake, rot_enable, rot_direction, target_angle,
            update_angle, abort_angle, rd_data, enable_hammer, enable_stall_chk, retry_count,
            consec_chg, fwd_count, rvs_count, delay_target, profile_offset, cruise_power}),
            '0);

    initial begin
        $display("Watchdog armed for %0d ns", WATCHDOG_NS);
        #(WATCHDOG_NS);
        $display("Watchdog expired, stimulus did not complete in time");
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        void'($urandom(41941));
        arst_n   = 1'b0;
        write_en = 1'b0;
        read_en  = 1'b0;
        address  = '0;
        wr_data  = '0;
        shuffle_status();
        repeat (RESET_CYCLES) @(posedge clock);
        @(negedge clock);
        arst_n = 1'b1;

        // Direct write then read back
        for (int a = 0; a < 64; a++) begin
            if (writable(a)) begin
                bus_cycle(1'b1, 1'b0, a, rand_byte());
                bus_cycle(1'b0, 1'b1, a, 8'h00);
            end
        end
        // Broadcast groups and reserved 0x00 each followed by a scan of the channel bytes
        for (int a = 0; a < 4; a++) begin
            bus_cycle(1'b1, 1'b0, a, rand_byte());
            for (int b = 4; b < 32; b++)
                bus_cycle(1'b0, 1'b1, b, 8'h00);
        end
        // Status held steady while the channel bytes are read
        repeat (4) begin
            shuffle_status();
            bus_cycle(1'b0, 1'b0, 6'h00, 8'h00);
            for (int b = 4; b < 32; b++)
                bus_cycle(1'b0, 1'b1, b, 8'h00);
        end
        // Back-to-back CURR2 commands per channel
        for (int ch = 0; ch < 4; ch++) begin
            bus_cycle(1'b1, 1'b0, rot_addr(ch, 4), 8'h30);  // Update and abort
            bus_cycle(1'b1, 1'b0, rot_addr(ch, 4), rand_byte());
            bus_cycle(1'b1, 1'b0, rot_addr(ch, 4), 8'h20);
        end
        bus_cycle(1'b0, 1'b0, 6'h00, 8'h00);
        // Unmapped and reserved reads each followed by an idle hold
        for (int a = 0; a < 64; a++) begin
            if (a < 4 || a > swerve_regs_pkg::ADDR_CRUISE) begin
                bus_cycle(1'b0, 1'b1, a, 8'h00);
                bus_cycle(1'b0, 1'b0, rand_byte(), 8'h00);
            end
        end
        // Free-running mixed traffic
        repeat (RAND_CYCLES) begin
            logic [31:0] w;
            w = $urandom;
            shuffle_status();
            bus_cycle(w[0], w[1], w[7:2], w[15:8]);
        end
        bus_cycle(1'b0, 1'b0, 6'h00, 8'h00);
        repeat (4) @(negedge clock);

        $display("Checked %0d cycles, %0d errors", cycles_checked, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* design/swerve_reg_file.sv */
/*
 Top of the swerve-drive register block. Wires the address decoder, four drive and
 four rotation channels, the rotation settings and the registered read port.
*/
`timescale 1ns/1ps

module swerve_reg_file (
    input  logic                                    clock,
    input  logic                                    arst_n,
    input  logic [swerve_regs_pkg::ADDR_W-1:0]      address,
    input  logic                                    write_en,
    input  swerve_regs_pkg::byte_t                  wr_data,
    input  logic                                    read_en,
    output swerve_regs_pkg::byte_t                  rd_data,
    // Drive motors
    input  logic [swerve_regs_pkg::NUM_DRIVE-1:0]   drive_fault,
    input  logic [swerve_regs_pkg::NUM_DRIVE-1:0][swerve_regs_pkg::DRIVE_TEMP_W-1:0] drive_temp,
    output logic [swerve_regs_pkg::NUM_DRIVE-1:0]   drive_brake,
    output logic [swerve_regs_pkg::NUM_DRIVE-1:0]   drive_enable,
    output logic [swerve_regs_pkg::NUM_DRIVE-1:0]   drive_direction,
    output logic [swerve_regs_pkg::NUM_DRIVE-1:0][swerve_regs_pkg::PWM_W-1:0] drive_pwm,
    // Rotation motors
    input  logic [swerve_regs_pkg::NUM_ROT-1:0]     rot_fault,
    input  logic [swerve_regs_pkg::NUM_ROT-1:0]     rot_startup_fail,
    input  logic [swerve_regs_pkg::NUM_ROT-1:0][swerve_regs_pkg::ROT_TEMP_W-1:0] rot_temp,
    output logic [swerve_regs_pkg::NUM_ROT-1:0]     rot_brake,
    output logic [swerve_regs_pkg::NUM_ROT-1:0]     rot_enable,
    output logic [swerve_regs_pkg::NUM_ROT-1:0]     rot_direction,
    output swerve_regs_pkg::angle_t [swerve_regs_pkg::NUM_ROT-1:0] target_angle,
    input  swerve_regs_pkg::angle_t [swerve_regs_pkg::NUM_ROT-1:0] current_angle,
    input  logic [swerve_regs_pkg::NUM_ROT-1:0]     angle_done,
    output logic [swerve_regs_pkg::NUM_ROT-1:0]     update_angle,
    output logic [swerve_regs_pkg::NUM_ROT-1:0]     abort_angle,
    // General rotation settings
    output logic                                    enable_hammer,
    output logic                                    enable_stall_chk,
    output logic [1:0]                              retry_count,
    output logic [2:0]                              consec_chg,
    output logic [3:0]                              fwd_count,
    output logic [3:0]                              rvs_count,
    output swerve_regs_pkg::byte_t                  delay_target,
    output swerve_regs_pkg::byte_t                  profile_offset,
    output swerve_regs_pkg::byte_t                  cruise_power
);

    swerve_regs_pkg::wr_strobe_t  wr_strobe;
    swerve_regs_pkg::reg_map_t    reg_map;
    swerve_regs_pkg::byte_t [4:0] settings_bytes;

    // Per-channel read bytes
    swerve_regs_pkg::byte_t [swerve_regs_pkg::NUM_DRIVE-1:0] drive_ctrl_b, drive_stat_b;
    swerve_regs_pkg::byte_t [swerve_regs_pkg::NUM_ROT-1:0]   rot_ctrl_b, rot_stat_b;
    swerve_regs_pkg::byte_t [swerve_regs_pkg::NUM_ROT-1:0]   rot_targ_b, rot_curr_b, rot_curr2_b;

    reg_addr_decode reg_addr_decode_inst (
        .address   (address),
        .write_en  (write_en),
        .wr_strobe (wr_strobe)
    );

    for (genvar i = 0; i < swerve_regs_pkg::NUM_DRIVE; i++) begin : g_drive
        localparam int CTRL = swerve_regs_pkg::DRIVE_BASE + swerve_regs_pkg::DRIVE_STRIDE * i;
        drive_channel drive_channel_inst (
            .clock (clock), .arst_n (arst_n),
            .ctrl_wr (wr_strobe[CTRL]), .wr_data (wr_data),
            .fault (drive_fault[i]), .temp (drive_temp[i]),
            .brake (drive_brake[i]), .enable (drive_enable[i]),
            .direction (drive_direction[i]), .pwm (drive_pwm[i]),
            .ctrl_byte (drive_ctrl_b[i]), .status_byte (drive_stat_b[i])
        );
    end

    for (genvar i = 0; i < swerve_regs_pkg::NUM_ROT; i++) begin : g_rot
        localparam int BASE = swerve_regs_pkg::ROT_BASE + swerve_regs_pkg::ROT_STRIDE * i;
        rotation_channel rotation_channel_inst (
            .clock (clock), .arst_n (arst_n),
            .ctrl_wr (wr_strobe[BASE + swerve_regs_pkg::ROT_CTRL_OFS]),
            .targ_wr (wr_strobe[BASE + swerve_regs_pkg::ROT_TARG_OFS]),
            .cmd_wr  (wr_strobe[BASE + swerve_regs_pkg::ROT_CURR2_OFS]),
            .wr_data (wr_data),
            .fault (rot_fault[i]), .startup_fail (rot_startup_fail[i]), .temp (rot_temp[i]),
            .current_angle (current_angle[i]), .angle_done (angle_done[i]),
            .brake (rot_brake[i]), .enable (rot_enable[i]), .direction (rot_direction[i]),
            .target_angle (target_angle[i]),
            .update_angle (update_angle[i]), .abort_angle (abort_angle[i]),
            .ctrl_byte (rot_ctrl_b[i]), .status_byte (rot_stat_b[i]),
            .curr_lo_byte (rot_curr_b[i]), .curr_hi_byte (rot_curr2_b[i])
        );
    end

    rotation_settings rotation_settings_inst (
        .clock (clock), .arst_n (arst_n),
        .wr_strobe (wr_strobe[swerve_regs_pkg::ADDR_CRUISE:swerve_regs_pkg::ADDR_GEN_CTRL]),
        .wr_data (wr_data),
        .enable_hammer (enable_hammer), .enable_stall_chk (enable_stall_chk),
        .retry_count (retry_count), .consec_chg (consec_chg),
        .fwd_count (fwd_count), .rvs_count (rvs_count),
        .delay_target (delay_target), .profile_offset (profile_offset),
        .cruise_power (cruise_power), .settings_bytes (settings_bytes)
    );

    // Map image, unmapped and reserved bytes stay zero
    always_comb begin
        reg_map = '0;
        for (int i = 0; i < swerve_regs_pkg::NUM_DRIVE; i++) begin
            reg_map[swerve_regs_pkg::DRIVE_BASE + swerve_regs_pkg::DRIVE_STRIDE * i]     = drive_ctrl_b[i];
            reg_map[swerve_regs_pkg::DRIVE_BASE + swerve_regs_pkg::DRIVE_STRIDE * i + 1] = drive_stat_b[i];
        end
        for (int i = 0; i < swerve_regs_pkg::NUM_ROT; i++) begin
            reg_map[swerve_regs_pkg::ROT_BASE + swerve_regs_pkg::ROT_STRIDE * i +
                    swerve_regs_pkg::ROT_CTRL_OFS]  = rot_ctrl_b[i];
            reg_map[swerve_regs_pkg::ROT_BASE + swerve_regs_pkg::ROT_STRIDE * i +
                    swerve_regs_pkg::ROT_STAT_OFS]  = rot_stat_b[i];
            reg_map[swerve_regs_pkg::ROT_BASE + swerve_regs_pkg::ROT_STRIDE * i +
                    swerve_regs_pkg::ROT_TARG_OFS]  = rot_targ_b[i];
            reg_map[swerve_regs_pkg::ROT_BASE + swerve_regs_pkg::ROT_STRIDE * i +
                    swerve_regs_pkg::ROT_CURR_OFS]  = rot_curr_b[i];
            reg_map[swerve_regs_pkg::ROT_BASE + swerve_regs_pkg::ROT_STRIDE * i +
                    swerve_regs_pkg::ROT_CURR2_OFS] = rot_curr2_b[i];
        end
        for (int k = 0; k < 5; k++)
            reg_map[swerve_regs_pkg::ADDR_GEN_CTRL + k] = settings_bytes[k];
    end

    // Target low byte is the lower half of the decoded angle
    for (genvar i = 0; i < swerve_regs_pkg::NUM_ROT; i++) begin : g_targ
        assign rot_targ_b[i] = target_angle[i][7:0];
    end

    read_return read_return_inst (
        .clock   (clock),
        .arst_n  (arst_n),
        .read_en (read_en),
        .address (address),
        .reg_map (reg_map),
        .rd_data (rd_data)
    );

endmodule

/* design/read_return.sv */
/*
 Read port. Selects one byte of the register image and registers it when read_en
 is high, so data arrives one cycle after the read and then holds.
*/
`timescale 1ns/1ps

module read_return (
    input  logic                               clock,
    input  logic                               arst_n,
    input  logic                               read_en,
    input  logic [swerve_regs_pkg::ADDR_W-1:0] address,
    input  swerve_regs_pkg::reg_map_t          reg_map,
    output swerve_regs_pkg::byte_t             rd_data
);

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n)
            rd_data <= '0;
        else if (read_en)
            rd_data <= reg_map[address];  // Unmapped bytes are tied low upstream
    end

    // A read selects through a known address
    read_addr_known: assert property (@(posedge clock) disable iff (!arst_n)
        read_en |-> !$isunknown(address))
        else $error("read issued with an unknown address");

endmodule

/* design/rotation_settings.sv */
/*
 General rotation settings at 0x20 to 0x24: hammer, retry and stall-check controls,
 delay target, profile offset and cruise power. Bytes are also returned for reads.
*/
`timescale 1ns/1ps

module rotation_settings (
    input  logic                         clock,
    input  logic                         arst_n,
    input  logic [4:0]                   wr_strobe,  // 0x20 in bit 0
    input  swerve_regs_pkg::byte_t       wr_data,
    output logic                         enable_hammer,
    output logic                         enable_stall_chk,
    output logic [1:0]                   retry_count,
    output logic [2:0]                   consec_chg,
    output logic [3:0]                   fwd_count,
    output logic [3:0]                   rvs_count,
    output swerve_regs_pkg::byte_t       delay_target,
    output swerve_regs_pkg::byte_t       profile_offset,
    output swerve_regs_pkg::byte_t       cruise_power,
    output swerve_regs_pkg::byte_t [4:0] settings_bytes
);

    swerve_regs_pkg::byte_t [4:0] regs_q;
    swerve_regs_pkg::gen_ctrl_t   gen;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            regs_q <= '0;
        end else begin
            for (int i = 0; i < 5; i++) begin
                if (wr_strobe[i])
                    regs_q[i] <= wr_data;
            end
        end
    end

    assign gen              = regs_q[0];
    assign enable_hammer    = gen.enable_hammer;  // Hammer vs linear ramp
    assign retry_count      = gen.retry_count;
    assign consec_chg       = gen.consec_chg;
    assign enable_stall_chk = gen.enable_stall_chk;

    // Forward count in the high nibble
    assign {fwd_count, rvs_count} =
        regs_q[swerve_regs_pkg::ADDR_HAMMER - swerve_regs_pkg::ADDR_GEN_CTRL];
    assign delay_target   = regs_q[swerve_regs_pkg::ADDR_DELAY - swerve_regs_pkg::ADDR_GEN_CTRL];
    assign profile_offset = regs_q[swerve_regs_pkg::ADDR_OFFSET - swerve_regs_pkg::ADDR_GEN_CTRL];
    assign cruise_power   = regs_q[swerve_regs_pkg::ADDR_CRUISE - swerve_regs_pkg::ADDR_GEN_CTRL];
    assign settings_bytes = regs_q;

endmodule

/* design/rotation_channel.sv */
/*
 Control and target-angle registers of one rotation motor, its sampled status and
 angle, and the update and abort pulses raised by a write to the CURR2 byte.
*/
`timescale 1ns/1ps

module rotation_channel (
    input  logic                                   clock,
    input  logic                                   arst_n,
    input  logic                                   ctrl_wr,
    input  logic                                   targ_wr,       // Target angle low byte
    input  logic                                   cmd_wr,        // CURR2 write
    input  swerve_regs_pkg::byte_t                 wr_data,
    input  logic                                   fault,
    input  logic                                   startup_fail,  // Stalled at startup
    input  logic [swerve_regs_pkg::ROT_TEMP_W-1:0] temp,
    input  swerve_regs_pkg::angle_t                current_angle,
    input  logic                                   angle_done,
    output logic                                   brake,
    output logic                                   enable,
    output logic                                   direction,
    output swerve_regs_pkg::angle_t                target_angle,
    output logic                                   update_angle,
    output logic                                   abort_angle,
    output swerve_regs_pkg::byte_t                 ctrl_byte,
    output swerve_regs_pkg::byte_t                 status_byte,
    output swerve_regs_pkg::byte_t                 curr_lo_byte,
    output swerve_regs_pkg::byte_t                 curr_hi_byte
);

    swerve_regs_pkg::rot_ctrl_t ctrl_q;
    swerve_regs_pkg::byte_t     targ_q;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            ctrl_q       <= '0;
            targ_q       <= '0;
            update_angle <= 1'b0;
            abort_angle  <= 1'b0;
        end else begin
            if (ctrl_wr)
                ctrl_q <= wr_data;
            if (targ_wr)
                targ_q <= wr_data;
            // Single-cycle commands that drop unless written again
            update_angle <= cmd_wr & wr_data[swerve_regs_pkg::UPDATE_BIT];
            abort_angle  <= cmd_wr & wr_data[swerve_regs_pkg::ABORT_BIT];
        end
    end

    // Status side runs one cycle behind the motor
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            status_byte  <= '0;
            curr_lo_byte <= '0;
            curr_hi_byte <= '0;
        end else begin
            status_byte  <= {fault, startup_fail, temp};
            curr_lo_byte <= current_angle[7:0];
            curr_hi_byte <= {angle_done, 3'b000, current_angle[11:8]};
        end
    end

    assign brake        = ctrl_q.brake;
    assign enable       = ctrl_q.enable;
    assign direction    = ctrl_q.direction;
    assign target_angle = {ctrl_q.angle_hi, targ_q};  // High nibble lives in control
    assign ctrl_byte    = ctrl_q;

    // Decode addresses one byte per write, so a channel sees at most one strobe
    one_strobe_per_channel: assert property (@(posedge clock) disable iff (!arst_n)
        $onehot0({ctrl_wr, targ_wr, cmd_wr}))
        else $error("more than one write strobe of a channel in one cycle");

endmodule

/* design/drive_channel.sv */
/*
 One drive motor: writable control byte split into brake, enable, direction and PWM,
 plus the status byte sampled from the motor every cycle.
*/
`timescale 1ns/1ps

module drive_channel (
    input  logic                                     clock,
    input  logic                                     arst_n,
    input  logic                                     ctrl_wr,     // From decode
    input  swerve_regs_pkg::byte_t                   wr_data,
    input  logic                                     fault,
    input  logic [swerve_regs_pkg::DRIVE_TEMP_W-1:0] temp,        // ADC temperature
    output logic                                     brake,
    output logic                                     enable,
    output logic                                     direction,
    output logic [swerve_regs_pkg::PWM_W-1:0]        pwm,
    output swerve_regs_pkg::byte_t                   ctrl_byte,
    output swerve_regs_pkg::byte_t                   status_byte
);

    swerve_regs_pkg::drive_ctrl_t ctrl_q;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            ctrl_q      <= '0;
            status_byte <= '0;
        end else begin
            if (ctrl_wr)
                ctrl_q <= wr_data;
            status_byte <= {fault, temp};  // Free-running sample
        end
    end

    assign brake     = ctrl_q.brake;
    assign enable    = ctrl_q.enable;
    assign direction = ctrl_q.direction;
    assign pwm       = ctrl_q.pwm;
    assign ctrl_byte = ctrl_q;  // Read back as written

endmodule

/* design/reg_addr_decode.sv */
/*
 Address decoder. Turns the address and write strobe into one write enable per
 byte, with the broadcast groups folded into the motor control enables.
*/
`timescale 1ns/1ps

module reg_addr_decode (
    input  logic [swerve_regs_pkg::ADDR_W-1:0] address,
    input  logic                               write_en,
    output swerve_regs_pkg::wr_strobe_t        wr_strobe
);

    logic bcast_drive;  // 0x01 or 0x03
    logic bcast_rot;    // 0x01 or 0x02

    assign bcast_drive = (address == swerve_regs_pkg::ADDR_BCAST_ALL) ||
                         (address == swerve_regs_pkg::ADDR_BCAST_DRIVE);
    assign bcast_rot   = (address == swerve_regs_pkg::ADDR_BCAST_ALL) ||
                         (address == swerve_regs_pkg::ADDR_BCAST_ROT);

    always_comb begin
        wr_strobe = '0;
        if (write_en) begin
            wr_strobe[address] = 1'b1;  // Direct hit
            for (int ch = 0; ch < swerve_regs_pkg::NUM_DRIVE; ch++) begin
                if (bcast_drive)
                    wr_strobe[swerve_regs_pkg::DRIVE_BASE +
                              swerve_regs_pkg::DRIVE_STRIDE * ch] = 1'b1;
            end
            for (int ch = 0; ch < swerve_regs_pkg::NUM_ROT; ch++) begin
                if (bcast_rot)
                    wr_strobe[swerve_regs_pkg::ROT_BASE + swerve_regs_pkg::ROT_STRIDE * ch +
                              swerve_regs_pkg::ROT_CTRL_OFS] = 1'b1;
            end
        end
    end

endmodule

/* design/swerve_regs_pkg.sv */
/*
 Register map of the swerve-drive control block: addresses, field layouts and widths.
 Every RTL file refers to these by scoped names.
*/
package swerve_regs_pkg;

    localparam int ADDR_W    = 6;   // Byte address
    localparam int DATA_W    = 8;
    localparam int MAP_DEPTH = 64;  // Full 6-bit address space

    localparam int NUM_DRIVE = 4;
    localparam int NUM_ROT   = 4;

    // Broadcast addresses, 0x00 reserved
    localparam int ADDR_BCAST_ALL   = 'h01;  // All eight motor control regs
    localparam int ADDR_BCAST_ROT   = 'h02;
    localparam int ADDR_BCAST_DRIVE = 'h03;

    // Drive channel: control byte then status byte
    localparam int DRIVE_BASE   = 'h04;
    localparam int DRIVE_STRIDE = 2;

    // Rotation channel, five bytes each
    localparam int ROT_BASE      = 'h0C;
    localparam int ROT_STRIDE    = 5;
    localparam int ROT_CTRL_OFS  = 0;
    localparam int ROT_STAT_OFS  = 1;
    localparam int ROT_TARG_OFS  = 2;  // Target angle low byte
    localparam int ROT_CURR_OFS  = 3;  // Current angle low byte
    localparam int ROT_CURR2_OFS = 4;  // Current angle high, command on write

    // General rotation settings
    localparam int ADDR_GEN_CTRL = 'h20;
    localparam int ADDR_HAMMER   = 'h21;
    localparam int ADDR_DELAY    = 'h22;
    localparam int ADDR_OFFSET   = 'h23;
    localparam int ADDR_CRUISE   = 'h24;

    localparam int ABORT_BIT  = 4;  // CURR2 write bits
    localparam int UPDATE_BIT = 5;

    localparam int ANGLE_W      = 12;
    localparam int PWM_W        = 5;
    localparam int DRIVE_TEMP_W = 7;
    localparam int ROT_TEMP_W   = 6;

    typedef logic [DATA_W-1:0]    byte_t;
    typedef logic [ANGLE_W-1:0]   angle_t;
    typedef logic [MAP_DEPTH-1:0] wr_strobe_t;  // One enable per address
    typedef byte_t [MAP_DEPTH-1:0] reg_map_t;   // Read image of the map

    typedef struct packed {
        logic             brake;
        logic             enable;
        logic             direction;
        logic [PWM_W-1:0] pwm;
    } drive_ctrl_t;

    typedef struct packed {
        logic       brake;
        logic       enable;
        logic       direction;
        logic       spare;
        logic [3:0] angle_hi;  // Target angle bits 11:8
    } rot_ctrl_t;

    typedef struct packed {
        logic       enable_hammer;
        logic [1:0] retry_count;  // Retries before giving up
        logic [2:0] consec_chg;
        logic       enable_stall_chk;
        logic       spare;
    } gen_ctrl_t;

endpackage
